/* verilog/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// first fetch address after reset
`define RESET_PC 32'hbfc0_0000

// instruction bus returns one doubleword per request
`define FETCH_WIDTH 64

// primary opcodes the decoder knows
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct field under OP_SPECIAL
`define FN_JR      6'h08

`endif

/* verilog/frontend_pkg.sv */
`include "frontend_defs.svh"

package frontend_pkg;

    // valid is a level held until addr_ok
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    // data shows up one cycle after acceptance
    // lower word belongs to the lower address
    typedef struct packed {
        logic                    addr_ok;
        logic [`FETCH_WIDTH-1:0] data;
    } ibus_resp_t;

    // one fetched instruction slot
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] raw;
        logic        adr_err;
    } fetch_slot_t;

    // register format view
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // immediate format view
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } instr_i_t;

    // one word decoded two ways
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        cls_alu_r,
        cls_alu_i,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,
        cls_unknown
    } instr_class_e;

    typedef struct packed {
        logic         valid;
        logic [31:0]  pc;
        instr_class_e cls;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic [4:0]   rdst;
        logic [31:0]  imm;
        logic         regwrite;
        logic         memtoreg;
        logic         is_ctrl;
        logic         adr_err;
    } decoded_t;

endpackage

/* verilog/fetch_unit.sv */
`timescale 1ns/10ps
`include "frontend_defs.svh"

module fetch_unit (
    input  logic                      clk,
    input  logic                      reset,
    output frontend_pkg::ibus_req_t   ireq,
    input  frontend_pkg::ibus_resp_t  iresp,
    input  logic                      stall,
    input  logic                      redirect_valid,
    input  logic [31:0]               redirect_pc,
    input  logic                      refetch,
    input  logic [31:0]               refetch_pc,
    output frontend_pkg::fetch_slot_t pair_f [2]
);
    logic [31:0]             pc;
    logic [31:0]             pc_seq;
    logic [31:0]             pc_target;
    logic                    misaligned;
    logic                    accept;
    logic                    can_move;
    logic                    refetch_go;
    logic                    pending;
    logic                    err_sent;
    logic                    redir_saved;
    logic [31:0]             redir_save_pc;
    logic                    f2_valid;
    logic [31:0]             f2_pc;
    logic                    f2_adr_err;
    logic                    slot_valid;
    logic                    raw_saved;
    logic [`FETCH_WIDTH-1:0] raw_save;
    logic [`FETCH_WIDTH-1:0] raw_data;

    // no bus request for a misaligned pc
    assign misaligned = pc[1:0] != 2'b00;
    assign ireq.valid = ~misaligned;
    assign ireq.addr  = pc;

    assign accept     = ireq.valid & iresp.addr_ok;
    assign can_move   = ~stall & (accept | misaligned);
    // refetch only counts once the buffer actually drops its pair
    assign refetch_go = refetch & ~stall;
    assign pending    = redirect_valid | refetch_go | redir_saved;

    assign pc_seq = pc[2] ? pc + 32'd4 : pc + 32'd8;

    always_comb begin
        if (redirect_valid) begin
            pc_target = redirect_pc;
        end else if (refetch_go) begin
            pc_target = refetch_pc;
        end else begin
            pc_target = redir_save_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (can_move) begin
            if (pending) begin
                pc <= pc_target;
            end else if (!misaligned) begin
                pc <= pc_seq;
            end
        end
    end

    // a misaligned pc yields one error slot and then waits for a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            err_sent <= 1'b0;
        end else if (can_move) begin
            err_sent <= ~pending & misaligned;
        end
    end

    // target held while the bus has not taken the current request
    always_ff @(posedge clk) begin
        if (reset || can_move) begin
            redir_saved <= 1'b0;
        end else if (redirect_valid || refetch_go) begin
            redir_saved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!can_move && (redirect_valid || refetch_go)) begin
            redir_save_pc <= pc_target;
        end
    end

    // anything issued toward a pending target is wrong path
    always_ff @(posedge clk) begin
        if (reset || redirect_valid) begin
            f2_valid <= 1'b0;
        end else if (!stall) begin
            f2_valid <= can_move & ~pending & ~(misaligned & err_sent);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            f2_pc <= pc;
        end
    end

    // keep the doubleword that lands in the first stall cycle until release
    always_ff @(posedge clk) begin
        if (reset) begin
            raw_saved <= 1'b0;
        end else begin
            raw_saved <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && !raw_saved) begin
            raw_save <= iresp.data;
        end
    end

    assign raw_data   = raw_saved ? raw_save : iresp.data;
    assign f2_adr_err = f2_pc[1:0] != 2'b00;
    assign slot_valid = f2_valid & ~redirect_valid;

    always_comb begin
        pair_f[0].valid   = slot_valid;
        pair_f[0].pc      = f2_pc;
        pair_f[0].raw     = f2_pc[2] ? raw_data[63:32] : raw_data[31:0];
        pair_f[0].adr_err = f2_adr_err;
        if (f2_adr_err) begin
            pair_f[0].raw = '0;
        end
        // younger slot only exists for a doubleword-aligned pc
        pair_f[1].valid   = slot_valid & ~f2_pc[2] & ~f2_adr_err;
        pair_f[1].pc      = f2_pc + 32'd4;
        pair_f[1].raw     = raw_data[63:32];
        pair_f[1].adr_err = 1'b0;
    end

endmodule

/* verilog/fetch_pair_reg.sv */
`timescale 1ns/10ps

module fetch_pair_reg (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  logic                      flush,
    input  frontend_pkg::fetch_slot_t in_pair  [2],
    output frontend_pkg::fetch_slot_t out_pair [2]
);
    logic [1:0]                vld_q;
    frontend_pkg::fetch_slot_t slot_q [2];

    // valid bits see reset and flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            vld_q <= 2'b00;
        end else if (en) begin
            vld_q <= {in_pair[1].valid, in_pair[0].valid};
        end
    end

    // slot contents just follow the enable
    always_ff @(posedge clk) begin
        if (en) begin
            slot_q[0] <= in_pair[0];
            slot_q[1] <= in_pair[1];
        end
    end

    always_comb begin
        out_pair[0]       = slot_q[0];
        out_pair[0].valid = vld_q[0];
        out_pair[1]       = slot_q[1];
        out_pair[1].valid = vld_q[1];
    end

endmodule

/* verilog/pair_decode.sv */
`timescale 1ns/10ps
`include "frontend_defs.svh"

module pair_decode (
    input  frontend_pkg::fetch_slot_t pair_d [2],
    output frontend_pkg::decoded_t    dec    [2],
    output logic                      refetch,
    output logic [31:0]               refetch_pc
);
    frontend_pkg::decoded_t dec_raw [2];

    function automatic frontend_pkg::decoded_t decode_slot(
        input frontend_pkg::fetch_slot_t s
    );
        frontend_pkg::decoded_t d;
        frontend_pkg::instr_u   w;
        w = s.raw;
        d = '0;
        d.valid = s.valid;
        d.pc    = s.pc;
        // rs and rt sit in the same place in both formats
        d.rs    = w.i.rs;
        d.rt    = w.i.rt;
        d.imm   = {{16{w.i.imm16[15]}}, w.i.imm16};
        d.cls   = frontend_pkg::cls_unknown;
        case (w.r.op)
            `OP_SPECIAL: begin
                if (w.r.funct == `FN_JR) begin
                    d.cls     = frontend_pkg::cls_jump;
                    d.is_ctrl = 1'b1;
                end else begin
                    d.cls      = frontend_pkg::cls_alu_r;
                    d.rdst     = w.r.rd;
                    d.regwrite = 1'b1;
                end
            end
            `OP_J: begin
                d.cls     = frontend_pkg::cls_jump;
                d.is_ctrl = 1'b1;
            end
            `OP_JAL: begin
                // link register
                d.cls      = frontend_pkg::cls_jump;
                d.rdst     = 5'd31;
                d.regwrite = 1'b1;
                d.is_ctrl  = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                d.cls     = frontend_pkg::cls_branch;
                d.is_ctrl = 1'b1;
            end
            `OP_ADDIU: begin
                d.cls      = frontend_pkg::cls_alu_i;
                d.rdst     = w.i.rt;
                d.regwrite = 1'b1;
            end
            `OP_LW: begin
                d.cls      = frontend_pkg::cls_load;
                d.rdst     = w.i.rt;
                d.regwrite = 1'b1;
                d.memtoreg = 1'b1;
            end
            `OP_SW: begin
                d.cls = frontend_pkg::cls_store;
            end
            default: begin
                d.cls = frontend_pkg::cls_unknown;
            end
        endcase
        // fetch address error overrides whatever the word said
        if (s.adr_err) begin
            d       = '0;
            d.valid = s.valid;
            d.pc    = s.pc;
            d.cls   = frontend_pkg::cls_unknown;
            d.adr_err = 1'b1;
        end
        return d;
    endfunction

    assign dec_raw[0] = decode_slot(pair_d[0]);
    assign dec_raw[1] = decode_slot(pair_d[1]);

    // control transfer in the younger slot has its delay slot outside the pair
    assign refetch    = dec_raw[1].valid & dec_raw[1].is_ctrl;
    assign refetch_pc = pair_d[1].pc;

    always_comb begin
        dec[0]       = dec_raw[0];
        dec[1]       = dec_raw[1];
        dec[1].valid = dec_raw[1].valid & ~refetch;
    end

endmodule

/* verilog/core_frontend.sv */
`timescale 1ns/10ps

module core_frontend (
    input  logic                     clk,
    input  logic                     reset,
    output frontend_pkg::ibus_req_t  ireq,
    input  frontend_pkg::ibus_resp_t iresp,
    input  logic                     stall,
    input  logic                     redirect_valid,
    input  logic [31:0]              redirect_pc,
    output frontend_pkg::decoded_t   dec [2]
);
    frontend_pkg::fetch_slot_t pair_f [2];
    frontend_pkg::fetch_slot_t pair_d [2];
    logic                      refetch;
    logic [31:0]               refetch_pc;
    logic                      buf_flush;
    logic                      buf_en;

    // refetch drops the pair only once the back end has taken slot 0
    assign buf_flush = redirect_valid | (refetch & ~stall);
    assign buf_en    = ~stall;

    fetch_unit i_fetch_unit (
        .clk,
        .reset,
        .ireq,
        .iresp,
        .stall,
        .redirect_valid,
        .redirect_pc,
        .refetch,
        .refetch_pc,
        .pair_f
    );

    fetch_pair_reg i_fetch_pair_reg (
        .clk,
        .reset,
        .en       (buf_en),
        .flush    (buf_flush),
        .in_pair  (pair_f),
        .out_pair (pair_d)
    );

    pair_decode i_pair_decode (
        .pair_d,
        .dec,
        .refetch,
        .refetch_pc
    );

endmodule

/* sim/tb_core_frontend.sv */
`timescale 1ns/10ps
`include "frontend_defs.svh"

module tb_core_frontend;
    localparam int NUM_TESTS = 2;

    logic                     clk;
    logic                     reset;
    frontend_pkg::ibus_req_t  ireq;
    frontend_pkg::ibus_resp_t iresp;
    logic                     stall;
    logic                     redirect_valid;
    logic [31:0]              redirect_pc;
    frontend_pkg::decoded_t   dec [2];

    // program image and expected stream from the trace
    logic [31:0]            mem [logic [31:0]];
    frontend_pkg::decoded_t exp_q [$];
    int                     rd_after [$];
    logic [31:0]            rd_target [$];
    logic                   rd_hold [$];

    frontend_pkg::decoded_t  prev_dec [2];
    frontend_pkg::ibus_req_t prev_req;
    logic                    loaded;
    logic                    active;
    logic                    random_mode;
    logic                    acc_q;
    logic [31:0]             acc_addr;
    logic                    stall_q;
    logic                    wait_q;
    logic                    redir_q;
    logic [31:0]             rnd;
    int                      count;
    int                      checked;
    int                      rd_idx;
    int                      errors;
    int                      cycle;
    int                      first_acc;
    int                      first_dec;

    core_frontend i_core_frontend (
        .clk,
        .reset,
        .ireq,
        .iresp,
        .stall,
        .redirect_valid,
        .redirect_pc,
        .dec
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // unused memory returns a pattern built from every address bit
        return addr ^ 32'h5a5a_c3c3;
    endfunction

    function automatic string decoded_text(input frontend_pkg::decoded_t d);
        return $sformatf("v=%b pc=%h cls=%0d rs=%0d rt=%0d rdst=%0d imm=%h flags=%b%b%b%b",
                         d.valid, d.pc, d.cls, d.rs, d.rt, d.rdst, d.imm,
                         d.regwrite, d.memtoreg, d.is_ctrl, d.adr_err);
    endfunction

    task automatic check_decoded(input string name, input frontend_pkg::decoded_t exp,
                                 input frontend_pkg::decoded_t act);
        if (act !== exp) begin
            errors++;
            $display("error %0t %s exp %s act %s", $time, name,
                     decoded_text(exp), decoded_text(act));
        end
    endtask

    task automatic check_ibus_req(input string name, input frontend_pkg::ibus_req_t exp,
                                  input frontend_pkg::ibus_req_t act);
        if (act !== exp) begin
            errors++;
            $display("error %0t %s exp valid=%b addr=%h act valid=%b addr=%h", $time, name,
                     exp.valid, exp.addr, act.valid, act.addr);
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error %0t %s exp %b act %b", $time, name, exp, act);
        end
    endtask

    task automatic read_trace(output bit ok);
        int                     fd;
        string                  line;
        logic [31:0]            a;
        logic [31:0]            w;
        int                     after;
        logic                   hold;
        logic [2:0]             cls;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rdst;
        logic [3:0]             flags;
        frontend_pkg::decoded_t d;
        fd = $fopen("sim/fetch_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2) begin
                    continue;
                end
                case (line.getc(0))
                    "p": begin
                        void'($sscanf(line, "p %h %h", a, w));
                        mem[a] = w;
                    end
                    "r": begin
                        void'($sscanf(line, "r %d %h %d", after, a, hold));
                        rd_after.push_back(after);
                        rd_target.push_back(a);
                        rd_hold.push_back(hold);
                    end
                    "e": begin
                        void'($sscanf(line, "e %h %d %d %d %d %h %b",
                                      a, cls, rs, rt, rdst, w, flags));
                        d = '0;
                        d.valid = 1'b1;
                        d.pc    = a;
                        d.cls   = frontend_pkg::instr_class_e'(cls);
                        d.rs    = rs;
                        d.rt    = rt;
                        d.rdst  = rdst;
                        d.imm   = w;
                        {d.regwrite, d.memtoreg, d.is_ctrl, d.adr_err} = flags;
                        exp_q.push_back(d);
                    end
                    default: begin
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // bus model with stall and redirect driven just after the edge
    always @(posedge clk) begin
        logic [31:0] base;
        #1;
        rnd  = xorshift32(rnd);
        base = {acc_addr[31:3], 3'b000};
        if (acc_q) begin
            iresp.data = {mem_word(base + 32'd4), mem_word(base)};
        end else begin
            iresp.data = {~acc_addr, acc_addr};
        end
        iresp.addr_ok  = random_mode ? (rnd[1:0] != 2'b00) : 1'b1;
        stall          = random_mode && (rnd[10:8] == 3'b000);
        redirect_valid = 1'b0;
        if (active && rd_idx < rd_after.size() && count == rd_after[rd_idx] + 1) begin
            redirect_valid = 1'b1;
            redirect_pc    = rd_target[rd_idx];
            // redirect while the bus is still waiting
            if (rd_hold[rd_idx]) begin
                iresp.addr_ok = 1'b0;
            end
            rd_idx++;
        end
    end

    // mid-cycle monitor
    always @(negedge clk) begin
        frontend_pkg::ibus_req_t exp_req;
        cycle++;
        acc_q    = ireq.valid & iresp.addr_ok;
        acc_addr = ireq.addr;
        if (active) begin
            exp_req.valid = (ireq.addr[1:0] == 2'b00);
            // address holds while stalled or while waiting for addr_ok
            exp_req.addr  = (stall_q || wait_q) ? prev_req.addr : ireq.addr;
            check_ibus_req("ireq", exp_req, ireq);
            if (acc_q && first_acc < 0) begin
                first_acc = cycle;
            end
            if (stall_q && !redir_q) begin
                check_decoded("dec[0] held under stall", prev_dec[0], dec[0]);
                check_decoded("dec[1] held under stall", prev_dec[1], dec[1]);
            end
            // pair shown during a redirect pulse is wrong path
            if (!stall && !redirect_valid) begin
                for (int i = 0; i < 2; i++) begin
                    if (dec[i].valid && count < exp_q.size()) begin
                        if (first_dec < 0) begin
                            first_dec = cycle;
                        end
                        check_decoded($sformatf("dec[%0d]", i), exp_q[count], dec[i]);
                        count++;
                        checked++;
                    end
                end
            end
            stall_q     = stall;
            wait_q      = ireq.valid & ~iresp.addr_ok;
            redir_q     = redirect_valid;
            prev_req    = ireq;
            prev_dec[0] = dec[0];
            prev_dec[1] = dec[1];
        end
    end

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(40 * exp_q.size() + 200) * NUM_TESTS * 20;
        #(limit_ns);
        $display("timeout: decoded stream did not complete within %0d ns", limit_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        bit                      ok;
        int                      test_errors;
        frontend_pkg::ibus_req_t reset_req;
        clk            = 1'b0;
        reset          = 1'b1;
        stall          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        iresp          = '0;
        loaded         = 1'b0;
        active         = 1'b0;
        random_mode    = 1'b0;
        acc_q          = 1'b0;
        acc_addr       = '0;
        rnd            = 32'h2ef81aaa;
        errors         = 0;
        checked        = 0;
        cycle          = 0;
        count          = 0;
        rd_idx         = 0;
        read_trace(ok);
        if (!ok) begin
            $display("trace file sim/fetch_trace.txt could not be opened");
            $display(">>> FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            reset_req.valid = 1'b1;
            reset_req.addr  = `RESET_PC;
            for (int t = 1; t <= NUM_TESTS; t++) begin
                test_errors = errors;
                // test 2 adds random bus waits and stalls
                random_mode = (t == 2);
                count     = 0;
                rd_idx    = 0;
                first_acc = -1;
                first_dec = -1;
                stall_q   = 1'b0;
                wait_q    = 1'b0;
                redir_q   = 1'b0;
                if (t > 1) begin
                    @(posedge clk);
                    #1;
                    reset = 1'b1;
                end
                repeat (2) @(posedge clk);
                #1;
                reset  = 1'b0;
                active = 1'b1;
                @(negedge clk);
                check_ibus_req("ireq after reset", reset_req, ireq);
                check_valid("dec[0].valid after reset", 1'b0, dec[0].valid);
                check_valid("dec[1].valid after reset", 1'b0, dec[1].valid);
                wait (count >= exp_q.size());
                active = 1'b0;
                if (t == 1 && first_dec - first_acc != 2) begin
                    errors++;
                    $display("error %0t first pair latency exp 2 act %0d", $time,
                             first_dec - first_acc);
                end
                $display("test %0d (%s): %0d entries, %0d errors", t,
                         random_mode ? "random waits and stalls" : "straight fetch",
                         count, errors - test_errors);
            end
            $display("tests %0d, entries checked %0d, errors %0d", NUM_TESTS, checked, errors);
            if (errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+verilog
verilog/frontend_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_pair_reg.sv
verilog/pair_decode.sv
verilog/core_frontend.sv
sim/tb_core_frontend.sv

/* Makefile */
TOOL      = verilator
TOP       = tb_core_frontend
RTL_TOP   = core_frontend
FILE_LIST = src.f
FLAGS     = --binary --timing -j 0
LINT      = --lint-only -Wall
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x '>>> PASS' $(LOG)

lint:
	$(TOOL) $(LINT) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/fetch_trace.txt */
# p <addr> <word> | r <after entry> <target> <hold addr_ok low>
# e <pc> <class 0..6> <rs> <rt> <rdst> <imm> <regwrite memtoreg is_ctrl adr_err>
p bfc00000 00221821
p bfc00004 2464fffb
p bfc00008 8c850010
p bfc0000c acc5fff8
p bfc00010 0c000010
p bfc00014 24027fff
p bfc00018 fc221234
p bfc0001c 10220004
p bfc00020 00a63821
p bfc00024 03e00008
p bfc00028 24080001
p bfc0002c 15000003
p bfc00030 01084821
p bfc00034 252a0002
p bfc00104 8d4bfffc
p bfc00108 ad4b0000
p bfc0010c 08000040
p bfc00110 00430821
p bfc00114 258cffff
p bfc00200 240d8000
p bfc00204 ac0d0004
p bfc00208 01ad7021
p bfc0020c 7c0f0010
e bfc00000 0 1 2 3 00001821 1000
e bfc00004 1 3 4 4 fffffffb 1000
e bfc00008 2 4 5 5 00000010 1100
e bfc0000c 3 6 5 0 fffffff8 0000
e bfc00010 5 0 0 31 00000010 1010
e bfc00014 1 0 2 2 00007fff 1000
e bfc00018 6 1 2 0 00001234 0000
e bfc0001c 4 1 2 0 00000004 0010
e bfc00020 0 5 6 7 00003821 1000
e bfc00024 5 31 0 0 00000008 0010
e bfc00028 1 0 8 8 00000001 1000
e bfc0002c 4 8 0 0 00000003 0010
e bfc00030 0 8 8 9 00004821 1000
e bfc00034 1 9 10 10 00000002 1000
r 13 bfc00104 0
e bfc00104 2 10 11 11 fffffffc 1100
e bfc00108 3 10 11 0 00000000 0000
e bfc0010c 5 0 0 0 00000040 0010
e bfc00110 0 2 3 1 00000821 1000
e bfc00114 1 12 12 12 ffffffff 1000
r 18 bfc00202 1
e bfc00202 6 0 0 0 00000000 0001
r 19 bfc00200 0
e bfc00200 1 0 13 13 ffff8000 1000
e bfc00204 3 0 13 0 00000004 0000
e bfc00208 0 13 13 14 00007021 1000
e bfc0020c 6 0 15 0 00000010 0000
